//--- common/kd_pkg.sv
package kd_pkg;

  // Patch geometry
  localparam int DIM_COUNT   = 5;                       // Coordinates per patch
  localparam int COORD_WIDTH = 11;                      // Signed, two's complement
  localparam int PATCH_WIDTH = DIM_COUNT * COORD_WIDTH; // Dimension 0 sits in the low bits

  // Node configuration word
  //   [2:0]   split dimension
  //   [10:3]  unused, reads back as zero
  //   [21:11] signed median
  localparam int DIM_WIDTH       = 3;
  localparam int NODE_WORD_WIDTH = 22;
  localparam int MEDIAN_LSB      = 11; // Median field runs up to the top bit

  // Reset state of a node
  // An out-of-range dimension makes the node compare a zero coordinate,
  // so with a zero median every patch goes right
  localparam logic [DIM_WIDTH-1:0] DIM_INVALID = 3'd7;

  // Tree shape
  localparam int DEFAULT_TREE_DEPTH = 4; // 15 internal nodes, 16 leaves

endpackage

//--- kd_tree/kd_internal_node.sv
`timescale 1ns/100ps

module kd_internal_node (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wen,
  input  logic [kd_pkg::NODE_WORD_WIDTH-1:0] wdata,
  input  logic                               valid_a,
  input  logic [kd_pkg::PATCH_WIDTH-1:0]     patch_a,
  input  logic                               valid_b,
  input  logic [kd_pkg::PATCH_WIDTH-1:0]     patch_b,
  output logic                               valid_left_a,
  output logic                               valid_right_a,
  output logic                               valid_left_b,
  output logic                               valid_right_b,
  output logic [kd_pkg::NODE_WORD_WIDTH-1:0] node_word
);

  logic        [kd_pkg::DIM_WIDTH-1:0]   dim;    // Split dimension
  logic signed [kd_pkg::COORD_WIDTH-1:0] median; // Split value
  logic signed [kd_pkg::COORD_WIDTH-1:0] coord_a;
  logic signed [kd_pkg::COORD_WIDTH-1:0] coord_b;
  logic                                  go_left_a;
  logic                                  go_left_b;

  // Pick the coordinate of the split dimension, zero for a bad index
  function automatic logic [kd_pkg::COORD_WIDTH-1:0] slice_coord(
    input logic [kd_pkg::PATCH_WIDTH-1:0] patch,
    input logic [kd_pkg::DIM_WIDTH-1:0]   sel
  );
    logic [kd_pkg::COORD_WIDTH-1:0] coord;
    coord = '0;
    for (int d = 0; d < kd_pkg::DIM_COUNT; d++) begin
      if (int'(sel) == d) begin
        coord = patch[d*kd_pkg::COORD_WIDTH +: kd_pkg::COORD_WIDTH];
      end
    end
    return coord;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dim    <= kd_pkg::DIM_INVALID;
      median <= '0;
    end else if (wen) begin
      dim    <= wdata[kd_pkg::DIM_WIDTH-1:0];
      median <= wdata[kd_pkg::NODE_WORD_WIDTH-1:kd_pkg::MEDIAN_LSB];
    end
  end

  assign coord_a = slice_coord(patch_a, dim);
  assign coord_b = slice_coord(patch_b, dim);

  assign go_left_a = coord_a < median; // Signed compare, equal goes right
  assign go_left_b = coord_b < median;

  assign valid_left_a  = valid_a && go_left_a;
  assign valid_right_a = valid_a && !go_left_a;
  assign valid_left_b  = valid_b && go_left_b;
  assign valid_right_b = valid_b && !go_left_b;

  // Read-back view, unused middle bits forced to zero
  assign node_word = {median, {(kd_pkg::MEDIAN_LSB - kd_pkg::DIM_WIDTH){1'b0}}, dim};

endmodule

//--- kd_tree/kd_search_pipe.sv
`timescale 1ns/100ps

module kd_search_pipe #(
  parameter int TREE_DEPTH = kd_pkg::DEFAULT_TREE_DEPTH
) (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic [2**TREE_DEPTH-2:0]                              node_wen,
  input  logic [kd_pkg::NODE_WORD_WIDTH-1:0]                    node_wdata,
  input  logic                                                  patch_valid,
  input  logic [kd_pkg::PATCH_WIDTH-1:0]                        patch_a,
  input  logic                                                  patch_valid_b,
  input  logic [kd_pkg::PATCH_WIDTH-1:0]                        patch_b,
  output logic [(2**TREE_DEPTH-1)*kd_pkg::NODE_WORD_WIDTH-1:0]  node_words,
  output logic [2**TREE_DEPTH-1:0]                              leaf_onehot_a,
  output logic [2**TREE_DEPTH-1:0]                              leaf_onehot_b
);

  localparam int NODE_COUNT = 2**TREE_DEPTH - 1;
  localparam int LEAF_COUNT = 2**TREE_DEPTH;
  localparam int HEAP_SIZE  = NODE_COUNT + LEAF_COUNT; // Nodes plus leaves
  localparam int WORD_W     = kd_pkg::NODE_WORD_WIDTH;

  // Patch registers, one per level
  logic [kd_pkg::PATCH_WIDTH-1:0] lvl_patch_a [TREE_DEPTH];
  logic [kd_pkg::PATCH_WIDTH-1:0] lvl_patch_b [TREE_DEPTH];

  // Valid registers in heap order, bit n feeds node n or is leaf n-NODE_COUNT
  logic [HEAP_SIZE-1:0] vld_a;
  logic [HEAP_SIZE-1:0] vld_b;

  // Steering results of every node, indexed by the child's heap number
  logic [HEAP_SIZE-1:1] child_a;
  logic [HEAP_SIZE-1:1] child_b;

  // Patches step down one level per clock beside their valids
  always_ff @(posedge clk) begin
    lvl_patch_a[0] <= patch_a;
    lvl_patch_b[0] <= patch_b;
    for (int l = 1; l < TREE_DEPTH; l++) begin
      lvl_patch_a[l] <= lvl_patch_a[l-1];
      lvl_patch_b[l] <= lvl_patch_b[l-1];
    end
  end

  // Root takes the lane valid, every other bit takes its parent's decision
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_a <= '0;
      vld_b <= '0;
    end else begin
      vld_a <= {child_a, patch_valid};
      vld_b <= {child_b, patch_valid_b};
    end
  end

  for (genvar lvl = 0; lvl < TREE_DEPTH; lvl++) begin : g_level
    for (genvar pos = 0; pos < 2**lvl; pos++) begin : g_node
      localparam int N = 2**lvl - 1 + pos; // Heap number

      kd_internal_node node_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .wen           (node_wen[N]),
        .wdata         (node_wdata),
        .valid_a       (vld_a[N]),
        .patch_a       (lvl_patch_a[lvl]),
        .valid_b       (vld_b[N]),
        .patch_b       (lvl_patch_b[lvl]),
        .valid_left_a  (child_a[2*N+1]),
        .valid_right_a (child_a[2*N+2]),
        .valid_left_b  (child_b[2*N+1]),
        .valid_right_b (child_b[2*N+2]),
        .node_word     (node_words[N*WORD_W +: WORD_W])
      );
    end
  end

  // Last level in heap order is already leaf order, left to right
  assign leaf_onehot_a = vld_a[HEAP_SIZE-1:NODE_COUNT];
  assign leaf_onehot_b = vld_b[HEAP_SIZE-1:NODE_COUNT];

endmodule

//--- rtl/node_cfg_wb.sv
`timescale 1ns/100ps

module node_cfg_wb #(
  parameter int TREE_DEPTH = kd_pkg::DEFAULT_TREE_DEPTH
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              wb_cyc,
  input  logic                                              wb_stb,
  input  logic                                              wb_we,
  input  logic [TREE_DEPTH-1:0]                             wb_adr,
  input  logic [kd_pkg::NODE_WORD_WIDTH-1:0]                wb_dat_w,
  output logic [kd_pkg::NODE_WORD_WIDTH-1:0]                wb_dat_r,
  output logic                                              wb_ack,
  output logic [2**TREE_DEPTH-2:0]                          node_wen,
  output logic [kd_pkg::NODE_WORD_WIDTH-1:0]                node_wdata,
  input  logic [(2**TREE_DEPTH-1)*kd_pkg::NODE_WORD_WIDTH-1:0] node_words
);

  localparam int NODE_COUNT = 2**TREE_DEPTH - 1;
  localparam int WORD_W     = kd_pkg::NODE_WORD_WIDTH;

  logic              req;     // New classic cycle not yet acknowledged
  logic              adr_ok;  // Address names an existing node
  logic              wr_req;
  logic [WORD_W-1:0] rd_word;

  assign req    = wb_cyc && wb_stb && !wb_ack;
  assign adr_ok = int'(wb_adr) < NODE_COUNT;
  assign wr_req = req && wb_we && adr_ok; // Out-of-range writes fall away here

  // Write data goes to every node and only the strobed one loads it
  assign node_wdata = wb_dat_w;

  // Heap-number decode shared by the write strobe and the read mux
  // Holes in the map keep the zero default
  always_comb begin
    node_wen = '0;
    rd_word  = '0;
    for (int n = 0; n < NODE_COUNT; n++) begin
      if (int'(wb_adr) == n) begin
        node_wen[n] = wr_req;
        rd_word     = node_words[n*WORD_W +: WORD_W];
      end
    end
  end

  // Single-cycle ack that drops on the edge after it rises
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // Read data lands together with ack
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_word;
    end
  end

endmodule

//--- rtl/leaf_encoder.sv
`timescale 1ns/100ps

module leaf_encoder #(
  parameter int TREE_DEPTH = kd_pkg::DEFAULT_TREE_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [2**TREE_DEPTH-1:0] leaf_onehot_a,
  input  logic [2**TREE_DEPTH-1:0] leaf_onehot_b,
  output logic                    leaf_valid_a,
  output logic [TREE_DEPTH-1:0]   leaf_index_a,
  output logic                    leaf_valid_b,
  output logic [TREE_DEPTH-1:0]   leaf_index_b
);

  localparam int LEAF_COUNT = 2**TREE_DEPTH;

  // Position of the set bit; the last hit in the scan is the highest
  function automatic logic [TREE_DEPTH-1:0] onehot_to_index(
    input logic [LEAF_COUNT-1:0] onehot
  );
    logic [TREE_DEPTH-1:0] idx;
    idx = '0;
    for (int i = 0; i < LEAF_COUNT; i++) begin
      if (onehot[i]) begin
        idx = TREE_DEPTH'(i);
      end
    end
    return idx;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      leaf_valid_a <= 1'b0;
      leaf_valid_b <= 1'b0;
    end else begin
      leaf_valid_a <= |leaf_onehot_a;
      leaf_valid_b <= |leaf_onehot_b;
    end
  end

  // Index is only meaningful while its valid is high
  always_ff @(posedge clk) begin
    leaf_index_a <= onehot_to_index(leaf_onehot_a);
    leaf_index_b <= onehot_to_index(leaf_onehot_b);
  end

endmodule

//--- rtl/kd_search_top.sv
`timescale 1ns/100ps

module kd_search_top #(
  parameter int TREE_DEPTH = kd_pkg::DEFAULT_TREE_DEPTH
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [TREE_DEPTH-1:0]              wb_adr,      // Node heap number
  input  logic [kd_pkg::NODE_WORD_WIDTH-1:0] wb_dat_w,
  output logic [kd_pkg::NODE_WORD_WIDTH-1:0] wb_dat_r,
  output logic                               wb_ack,
  input  logic                               patch_valid,
  input  logic [kd_pkg::PATCH_WIDTH-1:0]     patch_a,
  input  logic                               patch_valid_b,
  input  logic [kd_pkg::PATCH_WIDTH-1:0]     patch_b,
  output logic                               leaf_valid_a,
  output logic [TREE_DEPTH-1:0]              leaf_index_a,
  output logic                               leaf_valid_b,
  output logic [TREE_DEPTH-1:0]              leaf_index_b
);

  localparam int NODE_COUNT = 2**TREE_DEPTH - 1;
  localparam int LEAF_COUNT = 2**TREE_DEPTH;

  logic [NODE_COUNT-1:0]                         node_wen;   // One strobe per node
  logic [kd_pkg::NODE_WORD_WIDTH-1:0]            node_wdata;
  logic [NODE_COUNT*kd_pkg::NODE_WORD_WIDTH-1:0] node_words; // All words, node 0 lowest
  logic [LEAF_COUNT-1:0]                         leaf_onehot_a;
  logic [LEAF_COUNT-1:0]                         leaf_onehot_b;

  // Configuration port
  node_cfg_wb #(.TREE_DEPTH(TREE_DEPTH)) cfg_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .node_wen   (node_wen),
    .node_wdata (node_wdata),
    .node_words (node_words)
  );

  // TREE_DEPTH cycles of node levels
  kd_search_pipe #(.TREE_DEPTH(TREE_DEPTH)) pipe_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .node_wen      (node_wen),
    .node_wdata    (node_wdata),
    .patch_valid   (patch_valid),
    .patch_a       (patch_a),
    .patch_valid_b (patch_valid_b),
    .patch_b       (patch_b),
    .node_words    (node_words),
    .leaf_onehot_a (leaf_onehot_a),
    .leaf_onehot_b (leaf_onehot_b)
  );

  // One more cycle to leaf numbers
  leaf_encoder #(.TREE_DEPTH(TREE_DEPTH)) enc_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .leaf_onehot_a (leaf_onehot_a),
    .leaf_onehot_b (leaf_onehot_b),
    .leaf_valid_a  (leaf_valid_a),
    .leaf_index_a  (leaf_index_a),
    .leaf_valid_b  (leaf_valid_b),
    .leaf_index_b  (leaf_index_b)
  );

endmodule

//--- verification/kd_tb_clock.sv
`timescale 1ns/100ps

module kd_tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk; // 25 MHz
  end

  // Reset held for RESET_CYCLES rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- verification/kd_search_tb.sv
`timescale 1ns/100ps

module kd_search_tb;

  localparam int DEPTH   = 4;
  localparam int NODES   = 2**DEPTH - 1;
  localparam int LATENCY = DEPTH + 1;         // Patch in to leaf out
  localparam int ROWS    = 8;
  localparam int PW      = kd_pkg::PATCH_WIDTH;
  localparam int WW      = kd_pkg::NODE_WORD_WIDTH;
  localparam int CW      = kd_pkg::COORD_WIDTH;

  logic             clk;
  logic             rst_n;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [DEPTH-1:0] wb_adr;
  logic [WW-1:0]    wb_dat_w;
  logic [WW-1:0]    wb_dat_r;
  logic             wb_ack;
  logic             patch_valid;
  logic [PW-1:0]    patch_a;
  logic             patch_valid_b;
  logic [PW-1:0]    patch_b;
  logic             leaf_valid_a;
  logic [DEPTH-1:0] leaf_index_a;
  logic             leaf_valid_b;
  logic [DEPTH-1:0] leaf_index_b;

  logic [WW-1:0] node_tab [NODES];    // Tree used by the table rows
  logic [WW-1:0] model_words [NODES]; // What the DUT should hold now
  logic [PW-1:0] tab_a [ROWS];
  logic [PW-1:0] tab_b [ROWS];
  int            tab_leaf_a [ROWS];
  int            tab_leaf_b [ROWS];
  int            exp_leaf_a [$];      // Leaves in flight with the oldest first
  int            exp_due_a [$];       // Cycle count at which each must show
  int            exp_leaf_b [$];
  int            exp_due_b [$];
  int            cycle;
  int            errors;
  int            tests;
  int            leaves;
  int            test_start_errors;
  string         test_name;

  kd_tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(10)) clock_i (.clk(clk), .rst_n(rst_n));

  kd_search_top #(.TREE_DEPTH(DEPTH)) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .patch_valid   (patch_valid),
    .patch_a       (patch_a),
    .patch_valid_b (patch_valid_b),
    .patch_b       (patch_b),
    .leaf_valid_a  (leaf_valid_a),
    .leaf_index_a  (leaf_index_a),
    .leaf_valid_b  (leaf_valid_b),
    .leaf_index_b  (leaf_index_b)
  );

  always @(posedge clk) cycle <= cycle + 1; // Rising edges so far

  // Dimension 0 is the first argument and lands in the low bits
  function automatic logic [PW-1:0] make_patch(input int c0, c1, c2, c3, c4);
    return {c4[CW-1:0], c3[CW-1:0], c2[CW-1:0], c1[CW-1:0], c0[CW-1:0]};
  endfunction

  function automatic logic [WW-1:0] node_word(input int dim, input int median);
    return {median[CW-1:0], 8'h00, dim[kd_pkg::DIM_WIDTH-1:0]};
  endfunction

  function automatic logic [PW-1:0] random_patch();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[PW-1:0];
  endfunction

  // Reference walk going left when coordinate < median and taking path bits MSB first
  function automatic int leaf_of(input logic [PW-1:0] patch);
    int                 n;
    int                 idx;
    int                 dim;
    logic signed [CW-1:0] median;
    logic signed [CW-1:0] coord;
    n   = 0;
    idx = 0;
    for (int l = 0; l < DEPTH; l++) begin
      dim    = model_words[n][kd_pkg::DIM_WIDTH-1:0];
      median = model_words[n][WW-1:kd_pkg::MEDIAN_LSB];
      coord  = (dim < kd_pkg::DIM_COUNT) ? patch[dim*CW +: CW] : '0; // Bad dim reads zero
      idx    = 2 * idx + ((coord < median) ? 0 : 1);
      n      = 2 * n + ((coord < median) ? 1 : 2);
    end
    return idx;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic begin_test(input string name);
    test_name         = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("%s: %0d errors", test_name, errors - test_start_errors);
  endtask

  task automatic set_row(input int r, input logic [PW-1:0] pa, input int la,
                         input logic [PW-1:0] pb, input int lb);
    tab_a[r]      = pa;
    tab_leaf_a[r] = la;
    tab_b[r]      = pb;
    tab_leaf_b[r] = lb;
  endtask

  task automatic load_table();
    node_tab[0]  = node_word(0, 0);      // Root splits on dimension 0
    node_tab[1]  = node_word(1, -100);
    node_tab[2]  = node_word(1, 100);
    node_tab[3]  = node_word(2, -5);
    node_tab[4]  = node_word(2, 0);
    node_tab[5]  = node_word(2, 5);
    node_tab[6]  = node_word(2, 300);
    node_tab[7]  = node_word(3, -50);
    node_tab[8]  = node_word(3, 0);
    node_tab[9]  = node_word(3, 50);
    node_tab[10] = node_word(3, -1);
    node_tab[11] = node_word(4, 10);
    node_tab[12] = node_word(4, -10);
    node_tab[13] = node_word(4, 1023);   // Top of range
    node_tab[14] = node_word(4, -1023);  // Only -1024 goes left
    // Rows hit all 16 leaves with many coordinates sitting exactly on a median
    set_row(0, make_patch(0, 0, 0, 0, 0), 8, make_patch(-1, -100, -5, -50, 0), 4);
    set_row(1, make_patch(-1, -101, -6, -51, 0), 0, make_patch(-1024, -101, -5, -50, 0), 2);
    set_row(2, make_patch(-1, 0, 0, -1, 0), 7, make_patch(-1, 0, 0, -2, 0), 6);
    set_row(3, make_patch(0, 100, 299, 0, 1022), 12, make_patch(1023, 1023, 1023, 0, 1023), 15);
    set_row(4, make_patch(5, 99, 5, 0, -10), 11, make_patch(5, 99, 4, 0, 10), 9);
    set_row(5, make_patch(5, 99, 5, 0, -11), 10, make_patch(-1, -100, -5, 50, 0), 5);
    set_row(6, make_patch(0, 200, 299, 0, 1023), 13, make_patch(-1, -200, -4, 0, 0), 3);
    set_row(7, make_patch(-1, -200, -6, -50, 0), 1, make_patch(0, 200, 300, 0, -1024), 14);
  endtask

  // One classic cycle with ack expected one cycle after the request and for one cycle only
  task automatic bus_cycle(input logic we, input int adr, input logic [WW-1:0] wdat,
                           output logic [WW-1:0] rdat);
    int waited;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr[DEPTH-1:0];
    wb_dat_w = wdat;
    waited   = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 16);
    if (!wb_ack) begin
      $display("Timeout: no Wishbone ack for address %0d", adr);
      errors++;
    end else if (waited != 1) begin
      report_mismatch($sformatf("ack after %0d cycles at address %0d", waited, adr));
    end
    rdat   = wb_dat_r; // Valid while ack is high
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    if (wb_ack) report_mismatch($sformatf("ack held a second cycle at address %0d", adr));
  endtask

  task automatic bus_write(input int adr, input logic [WW-1:0] wdat);
    logic [WW-1:0] unused;
    bus_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic read_check(input int adr, input logic [WW-1:0] expected);
    logic [WW-1:0] rdat;
    bus_cycle(1'b0, adr, '0, rdat);
    if (rdat !== expected) begin
      report_mismatch($sformatf("node %0d reads %h, expected %h", adr, rdat, expected));
    end
  endtask

  task automatic send_pair(input logic va, input logic [PW-1:0] pa, input int la,
                           input logic vb, input logic [PW-1:0] pb, input int lb);
    @(negedge clk);
    patch_valid   = va;
    patch_a       = pa;
    patch_valid_b = vb;
    patch_b       = pb;
    // Sampled on the next rising edge and shown LATENCY edges later
    if (va) begin
      exp_leaf_a.push_back(la);
      exp_due_a.push_back(cycle + LATENCY + 1);
    end
    if (vb) begin
      exp_leaf_b.push_back(lb);
      exp_due_b.push_back(cycle + LATENCY + 1);
    end
  endtask

  task automatic drain();
    int waited;
    @(negedge clk);
    patch_valid   = 1'b0;
    patch_valid_b = 1'b0;
    waited        = 0;
    while ((exp_leaf_a.size() + exp_leaf_b.size()) != 0 && waited < 4 * LATENCY) begin
      @(negedge clk);
      waited++;
    end
    if ((exp_leaf_a.size() + exp_leaf_b.size()) != 0) begin
      $display("Timeout: %0d lane a and %0d lane b leaves never came out",
               exp_leaf_a.size(), exp_leaf_b.size());
      errors++;
      exp_leaf_a.delete();
      exp_due_a.delete();
      exp_leaf_b.delete();
      exp_due_b.delete();
    end
    repeat (2) @(negedge clk); // Room for a stray valid to show
  endtask

  // Outputs settle after the rising edge so they are sampled on the falling one
  always @(negedge clk) begin : leaf_monitor
    int want_leaf;
    int want_due;
    if (rst_n && leaf_valid_a) begin
      if (exp_leaf_a.size() == 0) begin
        report_mismatch("lane a leaf valid with no patch in flight");
      end else begin
        want_leaf = exp_leaf_a.pop_front();
        want_due  = exp_due_a.pop_front();
        leaves++;
        if (int'(leaf_index_a) != want_leaf || cycle != want_due) begin
          report_mismatch($sformatf("lane a leaf %0d at cycle %0d, expected %0d at cycle %0d",
                                    leaf_index_a, cycle, want_leaf, want_due));
        end
      end
    end
    if (rst_n && leaf_valid_b) begin
      if (exp_leaf_b.size() == 0) begin
        report_mismatch("lane b leaf valid with no patch in flight");
      end else begin
        want_leaf = exp_leaf_b.pop_front();
        want_due  = exp_due_b.pop_front();
        leaves++;
        if (int'(leaf_index_b) != want_leaf || cycle != want_due) begin
          report_mismatch($sformatf("lane b leaf %0d at cycle %0d, expected %0d at cycle %0d",
                                    leaf_index_b, cycle, want_leaf, want_due));
        end
      end
    end
  end

  initial begin
    int            seed_out;
    int            waited;
    int            c[5];
    logic [31:0]   r32;
    logic [WW-1:0] noise;
    logic [PW-1:0] pa;
    logic [PW-1:0] pb;
    seed_out      = $urandom(32'h34d8_1670);
    cycle         = 0;
    errors        = 0;
    tests         = 0;
    leaves        = 0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    patch_valid   = 1'b0;
    patch_a       = '0;
    patch_valid_b = 1'b0;
    patch_b       = '0;
    load_table();
    for (int n = 0; n < NODES; n++) model_words[n] = node_word(kd_pkg::DIM_INVALID, 0);

    waited = 0;
    while (rst_n !== 1'b1 && waited < 40) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      errors++;
    end

    begin_test("reset state");
    @(negedge clk);
    if (leaf_valid_a || leaf_valid_b || wb_ack) report_mismatch("valid or ack high after reset");
    for (int n = 0; n < NODES; n++) read_check(n, node_word(kd_pkg::DIM_INVALID, 0));
    send_pair(1'b1, random_patch(), NODES, 1'b1, random_patch(), NODES); // Every node steers right
    drain();
    end_test();

    begin_test("node write and read-back");
    for (int n = 0; n < NODES; n++) begin
      r32   = $urandom;
      noise = '0;
      noise[kd_pkg::MEDIAN_LSB-1:kd_pkg::DIM_WIDTH] = r32[7:0]; // Must not stick
      bus_write(n, node_tab[n] | noise);
      model_words[n] = node_tab[n];
    end
    for (int n = 0; n < NODES; n++) read_check(n, node_tab[n]);
    end_test();

    begin_test("table patches one at a time");
    for (int r = 0; r < ROWS; r++) begin
      if (leaf_of(tab_a[r]) != tab_leaf_a[r] || leaf_of(tab_b[r]) != tab_leaf_b[r]) begin
        report_mismatch($sformatf("reference walk disagrees with table row %0d", r));
      end
      send_pair(1'b1, tab_a[r], tab_leaf_a[r], 1'b1, tab_b[r], tab_leaf_b[r]);
      drain();
    end
    end_test();

    begin_test("back-to-back patches");
    for (int i = 0; i < ROWS + 40; i++) begin
      pa = (i < ROWS) ? tab_a[i] : random_patch();
      pb = (i < ROWS) ? tab_b[i] : random_patch();
      send_pair((i % 7) != 3, pa, leaf_of(pa), (i % 5) != 2, pb, leaf_of(pb));
    end
    drain();
    end_test();

    begin_test("root split on each dimension");
    for (int d = 0; d < kd_pkg::DIM_COUNT; d++) begin
      bus_write(0, node_word(d, -3));
      model_words[0] = node_word(d, -3);
      for (int i = 0; i < kd_pkg::DIM_COUNT; i++) c[i] = (i == d) ? -4 : 7;
      pa = make_patch(c[0], c[1], c[2], c[3], c[4]); // Just below the median so it goes left
      for (int i = 0; i < kd_pkg::DIM_COUNT; i++) c[i] = (i == d) ? -3 : -7;
      pb = make_patch(c[0], c[1], c[2], c[3], c[4]); // Equal to the median so it goes right
      send_pair(1'b1, pa, leaf_of(pa), 1'b1, pb, leaf_of(pb));
      drain();
    end
    bus_write(0, node_tab[0]);
    model_words[0] = node_tab[0];
    end_test();

    begin_test("address beyond last node");
    bus_write(NODES, node_word(2, 77));
    for (int n = 0; n < NODES; n++) read_check(n, model_words[n]);
    read_check(NODES, '0);
    end_test();

    $display("%0d tests, %0d leaves checked, %0d errors", tests, leaves, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
common/kd_pkg.sv
kd_tree/kd_internal_node.sv
kd_tree/kd_search_pipe.sv
rtl/node_cfg_wb.sv
rtl/leaf_encoder.sv
rtl/kd_search_top.sv
verification/kd_tb_clock.sv
verification/kd_search_tb.sv

//--- Bender.yml
package:
  name: kd_search

sources:
  - common/kd_pkg.sv
  - kd_tree/kd_internal_node.sv
  - kd_tree/kd_search_pipe.sv
  - rtl/node_cfg_wb.sv
  - rtl/leaf_encoder.sv
  - rtl/kd_search_top.sv
  - target: test
    files:
      - verification/kd_tb_clock.sv
      - verification/kd_search_tb.sv
